// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // --------------------
    // Scalar types
    // --------------------

    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    typedef enum logic [7:0] {
        OP_ADD     = 8'h01,
        OP_SUB     = 8'h02,
        OP_MUL     = 8'h03,
        OP_AND     = 8'h04,
        OP_OR      = 8'h05,
        OP_NOT     = 8'h06,
        OP_RSHIFT  = 8'h07,
        OP_LSHIFT  = 8'h08,
        OP_MOVE    = 8'h09,
        OP_MOVEOUT = 8'h0a,
        OP_MOVEIN  = 8'h0b,
        OP_JUMP    = 8'h0c,
        OP_EJUMP   = 8'h0d,
        OP_NEJUMP  = 8'h0e,
        OP_WAIT    = 8'h0f
    } exec_op_e;

    // Fixed registers
    localparam reg_addr_t REG_ZERO    = 5'd0;
    localparam reg_addr_t REG_CARRY   = 5'd1;
    localparam reg_addr_t REG_NEG     = 5'd2;
    localparam reg_addr_t REG_PROD_HI = 5'd3;
    localparam reg_addr_t REG_PROD_LO = 5'd4;
    localparam reg_addr_t REG_LOAD    = 5'd5;

    localparam byte_t FLAG_SET   = 8'd1;
    localparam byte_t FLAG_CLEAR = 8'd0;

    // Wait codes that freeze the counter
    localparam logic [1:0] WAIT_HOLD      = 2'b01;
    localparam logic [1:0] WAIT_HOLD_HIGH = 2'b11;

    // --------------------
    // Bundles
    // --------------------

    // Register pair, as two operands or as one address
    typedef union packed {
        struct packed {
            byte_t hi;
            byte_t lo;
        } bytes;
        word_t word;
    } byte_pair_u;

    typedef struct packed {
        exec_op_e   op;
        logic       use_imm;
        logic       step_mode;
        logic [1:0] wait_ctrl;
        reg_addr_t  dst_a;
        reg_addr_t  dst_b;
        reg_addr_t  dst_c;
        byte_t      imm;
        byte_t      ram_rdata;
        byte_pair_u src_ab;
        byte_pair_u src_cd;
        word_t      pc;
    } exec_req_t;

    typedef struct packed {
        byte_t     opa;
        byte_t     opb;
        reg_addr_t dst;
        logic      form_ok;
    } operands_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr1;
        byte_t     data1;
        reg_addr_t addr2;
        byte_t     data2;
    } reg_wr_t;

    typedef struct packed {
        logic  en;
        word_t addr;
        byte_t data;
    } ram_wr_t;

endpackage

`default_nettype wire

// ==== design/operand_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_select (
    input  exec_pkg::exec_req_t req_i,
    output exec_pkg::operands_t opnd_o
);

    import exec_pkg::*;

    byte_t rd1;
    byte_t rd2;

    assign rd1 = req_i.src_ab.bytes.hi;
    assign rd2 = req_i.src_ab.bytes.lo;

    // --------------------
    // Operand and form decode
    // --------------------

    always_comb begin
        // Binary form by default
        opnd_o.opa     = rd1;
        opnd_o.form_ok = 1'b1;
        if (req_i.use_imm) begin
            opnd_o.opb = req_i.imm;
            opnd_o.dst = req_i.dst_b;
        end
        else begin
            opnd_o.opb = rd2;
            opnd_o.dst = req_i.dst_c;
        end

        case (req_i.op)
            OP_NOT, OP_MOVE: begin
                // Single source, destination shifts down one slot
                if (req_i.use_imm) begin
                    opnd_o.opa = req_i.imm;
                    opnd_o.dst = req_i.dst_a;
                end
                else begin
                    opnd_o.opa = rd1;
                    opnd_o.dst = req_i.dst_b;
                end
            end
            OP_MOVEOUT, OP_JUMP, OP_EJUMP, OP_NEJUMP: begin
                // Register form only
                opnd_o.form_ok = !req_i.use_imm;
            end
            OP_MOVEIN: begin
                opnd_o.form_ok = req_i.use_imm;
            end
            default: begin
                opnd_o.form_ok = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/result_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_unit (
    input  logic                clk_i,
    input  logic                rst_i,
    input  exec_pkg::exec_req_t req_i,
    input  exec_pkg::operands_t opnd_i,
    output exec_pkg::reg_wr_t   reg_wr_o,
    output exec_pkg::ram_wr_t   ram_wr_o
);

    import exec_pkg::*;

    word_t   product;
    byte_t   logic_res;
    reg_wr_t reg_wr_d;
    ram_wr_t ram_wr_d;

    // --------------------
    // Datapath
    // --------------------

    assign product = opnd_i.opa * opnd_i.opb;

    always_comb begin
        case (req_i.op)
            OP_AND: begin
                logic_res = opnd_i.opa & opnd_i.opb;
            end
            OP_OR: begin
                logic_res = opnd_i.opa | opnd_i.opb;
            end
            OP_NOT: begin
                logic_res = ~opnd_i.opa;
            end
            OP_RSHIFT: begin
                logic_res = opnd_i.opa >> opnd_i.opb;
            end
            OP_LSHIFT: begin
                logic_res = opnd_i.opa << opnd_i.opb;
            end
            default: begin
                // MOVE passes the source through
                logic_res = opnd_i.opa;
            end
        endcase
    end

    // --------------------
    // Write decode
    // --------------------

    always_comb begin
        reg_wr_d = '0;
        ram_wr_d = '0;

        case (req_i.op)
            OP_ADD: begin
                reg_wr_d.en    = 1'b1;
                reg_wr_d.addr1 = opnd_i.dst;
                reg_wr_d.data1 = opnd_i.opa + opnd_i.opb;
                reg_wr_d.addr2 = REG_CARRY;
                if (opnd_i.opa[7] && opnd_i.opb[7]) begin
                    reg_wr_d.data2 = FLAG_SET;
                end
                else begin
                    reg_wr_d.data2 = FLAG_CLEAR;
                end
            end
            OP_SUB: begin
                reg_wr_d.en    = 1'b1;
                reg_wr_d.addr1 = opnd_i.dst;
                reg_wr_d.data1 = opnd_i.opa - opnd_i.opb;
                reg_wr_d.addr2 = REG_NEG;
                if (opnd_i.opb > opnd_i.opa) begin
                    reg_wr_d.data2 = FLAG_SET;
                end
                else begin
                    reg_wr_d.data2 = FLAG_CLEAR;
                end
            end
            OP_MUL: begin
                // Product split across the fixed pair
                reg_wr_d.en    = 1'b1;
                reg_wr_d.addr1 = REG_PROD_HI;
                reg_wr_d.data1 = product[15:8];
                reg_wr_d.addr2 = REG_PROD_LO;
                reg_wr_d.data2 = product[7:0];
            end
            OP_AND, OP_OR, OP_NOT, OP_RSHIFT, OP_LSHIFT, OP_MOVE: begin
                reg_wr_d.en    = 1'b1;
                reg_wr_d.addr1 = opnd_i.dst;
                reg_wr_d.data1 = logic_res;
                reg_wr_d.addr2 = REG_ZERO;
                reg_wr_d.data2 = 8'h00;
            end
            OP_MOVEOUT: begin
                if (opnd_i.form_ok) begin
                    ram_wr_d.en   = 1'b1;
                    ram_wr_d.addr = req_i.src_ab.word;
                    ram_wr_d.data = req_i.src_ab.bytes.hi;
                end
            end
            OP_MOVEIN: begin
                if (opnd_i.form_ok) begin
                    reg_wr_d.en    = 1'b1;
                    reg_wr_d.addr1 = REG_LOAD;
                    reg_wr_d.data1 = req_i.ram_rdata;
                    reg_wr_d.addr2 = REG_ZERO;
                    reg_wr_d.data2 = 8'h00;
                end
            end
            default: begin
                // Jumps, wait and unknown codes write nothing
                reg_wr_d = '0;
            end
        endcase
    end

    // --------------------
    // Output registers
    // --------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reg_wr_o <= '0;
            ram_wr_o <= '0;
        end
        else begin
            reg_wr_o <= reg_wr_d;
            ram_wr_o <= ram_wr_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_unit #(
    parameter exec_pkg::word_t ROM_LAST = 16'h00ff
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  exec_pkg::exec_req_t req_i,
    input  exec_pkg::operands_t opnd_i,
    output exec_pkg::word_t     pc_o
);

    import exec_pkg::*;

    word_t pc_inc;
    word_t pc_seq;
    word_t pc_d;
    logic  ops_equal;

    assign pc_inc    = req_i.pc + 16'd1;
    assign ops_equal = (opnd_i.opa == opnd_i.opb);

    // Step mode freezes, otherwise wrap after the last ROM word
    always_comb begin
        if (req_i.step_mode) begin
            pc_seq = req_i.pc;
        end
        else if (req_i.pc >= ROM_LAST) begin
            pc_seq = '0;
        end
        else begin
            pc_seq = pc_inc;
        end
    end

    always_comb begin
        pc_d = pc_seq;
        case (req_i.op)
            OP_JUMP, OP_EJUMP, OP_NEJUMP: begin
                // Branches skip the wrap check
                pc_d = pc_inc;
                if (opnd_i.form_ok) begin
                    if (req_i.op == OP_JUMP) begin
                        pc_d = req_i.src_ab.word;
                    end
                    else if ((req_i.op == OP_EJUMP) == ops_equal) begin
                        pc_d = req_i.src_cd.word;
                    end
                end
            end
            OP_WAIT: begin
                if (req_i.wait_ctrl == WAIT_HOLD || req_i.wait_ctrl == WAIT_HOLD_HIGH) begin
                    pc_d = req_i.pc;
                end
            end
            default: begin
                pc_d = pc_seq;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= '0;
        end
        else begin
            pc_o <= pc_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage #(
    parameter exec_pkg::word_t ROM_LAST = 16'h00ff
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  exec_pkg::exec_req_t req_i,
    output exec_pkg::reg_wr_t   reg_wr_o,
    output exec_pkg::ram_wr_t   ram_wr_o,
    output exec_pkg::word_t     pc_o
);

    import exec_pkg::*;

    operands_t opnd;

    // --------------------
    // Operand decode
    // --------------------

    operand_select operand_select_inst (
        .req_i  (req_i),
        .opnd_o (opnd)
    );

    // --------------------
    // Register and RAM writes
    // --------------------

    result_unit result_unit_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .opnd_i   (opnd),
        .reg_wr_o (reg_wr_o),
        .ram_wr_o (ram_wr_o)
    );

    // --------------------
    // Program counter
    // --------------------

    pc_unit #(
        .ROM_LAST (ROM_LAST)
    ) pc_unit_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .opnd_i (opnd),
        .pc_o   (pc_o)
    );

endmodule

`default_nettype wire

// ==== bench/exec_stage_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage_properties (
    input logic                clk_i,
    input logic                rst_i,
    input exec_pkg::exec_req_t req_i,
    input exec_pkg::reg_wr_t   reg_wr_o,
    input exec_pkg::ram_wr_t   ram_wr_o
);

    import exec_pkg::*;

    // Register file and RAM never written by the same request
    single_writer: assert property (@(posedge clk_i) disable iff (rst_i)
        !(reg_wr_o.en && ram_wr_o.en))
        else $error("register write and RAM store enabled together");

    quiet_after_reset: assert property (@(posedge clk_i)
        rst_i |=> (!reg_wr_o.en && !ram_wr_o.en))
        else $error("write enable high right after a reset cycle");

    store_after_moveout: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ram_wr_o.en) |-> $past(req_i.op == OP_MOVEOUT))
        else $error("RAM store without a MOVEOUT request one cycle before");

endmodule

bind exec_stage exec_stage_properties exec_stage_properties_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .reg_wr_o (reg_wr_o),
    .ram_wr_o (ram_wr_o)
);

`default_nettype wire

// ==== include/exec_vectors.svh ====
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// Request and the outputs expected one cycle later
typedef struct packed {
    exec_pkg::exec_req_t req;
    exec_pkg::reg_wr_t   reg_wr;
    exec_pkg::ram_wr_t   ram_wr;
    exec_pkg::word_t     pc;
} exec_vec_t;

localparam int NUM_VECTORS = 11;

// Request order: op, use_imm, step_mode, wait_ctrl, dst_a, dst_b, dst_c,
// imm, ram_rdata, src_ab, src_cd, pc
localparam exec_vec_t EXEC_VECTORS [NUM_VECTORS] = '{
    '{'{exec_pkg::OP_ADD, 1'b1, 1'b0, 2'b00, 5'd0, 5'd7, 5'd0, 8'h90, 8'h00,
        16'h8000, 16'h0000, 16'h0010},
      '{1'b1, 5'd7, 8'h10, 5'd1, 8'h01}, '{1'b0, 16'h0000, 8'h00}, 16'h0011},
    '{'{exec_pkg::OP_SUB, 1'b0, 1'b0, 2'b00, 5'd0, 5'd0, 5'd10, 8'h00, 8'h00,
        16'h0305, 16'h0000, 16'h0030},
      '{1'b1, 5'd10, 8'hfe, 5'd2, 8'h01}, '{1'b0, 16'h0000, 8'h00}, 16'h0031},
    '{'{exec_pkg::OP_MUL, 1'b1, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 8'h34, 8'h00,
        16'h1200, 16'h0000, 16'h0040},
      '{1'b1, 5'd3, 8'h03, 5'd4, 8'ha8}, '{1'b0, 16'h0000, 8'h00}, 16'h0041},
    '{'{exec_pkg::OP_NOT, 1'b1, 1'b0, 2'b00, 5'd6, 5'd0, 5'd0, 8'h5a, 8'h00,
        16'h0000, 16'h0000, 16'h0050},
      '{1'b1, 5'd6, 8'ha5, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h0051},
    '{'{exec_pkg::OP_MOVEOUT, 1'b0, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 8'h00, 8'h00,
        16'h4412, 16'h0000, 16'h0060},
      '{1'b0, 5'd0, 8'h00, 5'd0, 8'h00}, '{1'b1, 16'h4412, 8'h44}, 16'h0061},
    '{'{exec_pkg::OP_MOVEIN, 1'b1, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 8'h00, 8'h77,
        16'h0000, 16'h0000, 16'h0070},
      '{1'b1, 5'd5, 8'h77, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h0071},
    '{'{exec_pkg::OP_EJUMP, 1'b0, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 8'h00, 8'h00,
        16'h5555, 16'h00aa, 16'h0080},
      '{1'b0, 5'd0, 8'h00, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h00aa},
    '{'{exec_pkg::OP_NEJUMP, 1'b1, 1'b0, 2'b00, 5'd0, 5'd0, 5'd0, 8'h00, 8'h00,
        16'h1234, 16'h0042, 16'h00ff},
      '{1'b0, 5'd0, 8'h00, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h0100},
    '{'{exec_pkg::OP_WAIT, 1'b0, 1'b0, 2'b11, 5'd0, 5'd0, 5'd0, 8'h00, 8'h00,
        16'h0000, 16'h0000, 16'h0090},
      '{1'b0, 5'd0, 8'h00, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h0090},
    '{'{exec_pkg::OP_OR, 1'b1, 1'b1, 2'b00, 5'd0, 5'd8, 5'd0, 8'h0f, 8'h00,
        16'hf000, 16'h0000, 16'h00a0},
      '{1'b1, 5'd8, 8'hff, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h00a0},
    '{'{exec_pkg::OP_AND, 1'b0, 1'b0, 2'b00, 5'd0, 5'd0, 5'd11, 8'h00, 8'h00,
        16'hf03c, 16'h0000, 16'h00ff},
      '{1'b1, 5'd11, 8'h30, 5'd0, 8'h00}, '{1'b0, 16'h0000, 8'h00}, 16'h0000}
};

`endif

// ==== bench/exec_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage_tb;

    import exec_pkg::*;

    `include "exec_vectors.svh"

    localparam word_t       ROM_LAST       = 16'h00ff;
    localparam int          RESET_CYCLES   = 4;
    localparam int          NUM_RANDOM     = 200;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + NUM_RANDOM + 20;
    localparam logic [31:0] LFSR_SEED      = 32'h113e;

    // Operands as the form rules pick them
    typedef struct packed {
        byte_t     a;
        byte_t     b;
        reg_addr_t dst;
    } ref_opnd_t;

    logic      clk_i = 1'b0;
    logic      rst_i;
    exec_req_t req_i;
    reg_wr_t   reg_wr;
    ram_wr_t   ram_wr;
    word_t     pc;

    int          cycle_count = 0;
    logic [31:0] lfsr_state;

    // Expected outputs of the request applied one edge earlier
    logic    pend_valid;
    string   pend_name;
    reg_wr_t pend_reg;
    ram_wr_t pend_ram;
    word_t   pend_pc;

    exec_stage #(
        .ROM_LAST (ROM_LAST)
    ) exec_stage_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .reg_wr_o (reg_wr),
        .ram_wr_o (ram_wr),
        .pc_o     (pc)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------
    // Random stimulus
    // --------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 32'h8020_0003;
        end
        else begin
            lfsr_next = s >> 1;
        end
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic exec_op_e pick_op(input logic [3:0] idx);
        exec_op_e ops [15];
        ops = '{OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_NOT, OP_RSHIFT, OP_LSHIFT,
                OP_MOVE, OP_MOVEOUT, OP_MOVEIN, OP_JUMP, OP_EJUMP, OP_NEJUMP, OP_WAIT};
        if (idx == 4'hf) begin
            // A code outside the opcode set
            pick_op = exec_op_e'(8'hc3);
        end
        else begin
            pick_op = ops[idx];
        end
    endfunction

    task automatic build_random_req(output exec_req_t r);
        logic [31:0] v;
        r = '0;
        draw_bits(4, v);
        r.op = pick_op(v[3:0]);
        draw_bits(1, v);
        r.use_imm = v[0];
        draw_bits(3, v);
        r.step_mode = (v[2:0] == 3'b111);
        draw_bits(2, v);
        r.wait_ctrl = v[1:0];
        draw_bits(15, v);
        r.dst_a = v[14:10];
        r.dst_b = v[9:5];
        r.dst_c = v[4:0];
        draw_bits(16, v);
        r.imm       = v[15:8];
        r.ram_rdata = v[7:0];
        draw_bits(16, v);
        r.src_ab.word = v[15:0];
        // Equal bytes half the time for the branch compare
        draw_bits(1, v);
        if (v[0]) begin
            r.src_ab.bytes.lo = r.src_ab.bytes.hi;
        end
        draw_bits(16, v);
        r.src_cd.word = v[15:0];
        draw_bits(2, v);
        if (v[1:0] == 2'd0) begin
            r.pc = ROM_LAST;
        end
        else if (v[1:0] == 2'd1) begin
            draw_bits(16, v);
            r.pc = v[15:0];
        end
        else begin
            draw_bits(8, v);
            r.pc = {8'h00, v[7:0]};
        end
    endtask

    // A request that writes something if reset does not hold the outputs
    function automatic exec_req_t reset_busy_req(input logic store);
        exec_req_t r;
        r             = '0;
        r.pc          = 16'h0033;
        r.src_ab.word = 16'h6c21;
        if (store) begin
            r.op = OP_MOVEOUT;
        end
        else begin
            r.op      = OP_ADD;
            r.use_imm = 1'b1;
            r.dst_b   = 5'd9;
            r.imm     = 8'h45;
        end
        return r;
    endfunction

    // --------------------
    // Reference rules
    // --------------------

    function automatic ref_opnd_t select_operands(input exec_req_t r);
        ref_opnd_t o;
        o.a = r.src_ab.bytes.hi;
        o.b = r.use_imm ? r.imm : r.src_ab.bytes.lo;
        o.dst = r.use_imm ? r.dst_b : r.dst_c;
        if (r.op == OP_NOT || r.op == OP_MOVE) begin
            o.a   = r.use_imm ? r.imm : r.src_ab.bytes.hi;
            o.dst = r.use_imm ? r.dst_a : r.dst_b;
        end
        return o;
    endfunction

    function automatic reg_wr_t reg_write_model(input exec_req_t r);
        ref_opnd_t   o;
        reg_wr_t     w;
        logic [15:0] prod;
        o    = select_operands(r);
        w    = '0;
        prod = {8'h00, o.a} * {8'h00, o.b};
        case (r.op)
            OP_ADD:
                w = '{1'b1, o.dst, o.a + o.b, REG_CARRY,
                      (o.a[7] && o.b[7]) ? FLAG_SET : FLAG_CLEAR};
            OP_SUB:
                w = '{1'b1, o.dst, o.a - o.b, REG_NEG, (o.b > o.a) ? FLAG_SET : FLAG_CLEAR};
            OP_MUL:
                w = '{1'b1, REG_PROD_HI, prod[15:8], REG_PROD_LO, prod[7:0]};
            OP_AND:    w = '{1'b1, o.dst, o.a & o.b, REG_ZERO, 8'h00};
            OP_OR:     w = '{1'b1, o.dst, o.a | o.b, REG_ZERO, 8'h00};
            OP_NOT:    w = '{1'b1, o.dst, ~o.a, REG_ZERO, 8'h00};
            OP_RSHIFT: w = '{1'b1, o.dst, o.a >> o.b, REG_ZERO, 8'h00};
            OP_LSHIFT: w = '{1'b1, o.dst, o.a << o.b, REG_ZERO, 8'h00};
            OP_MOVE:   w = '{1'b1, o.dst, o.a, REG_ZERO, 8'h00};
            OP_MOVEIN: begin
                if (r.use_imm) begin
                    w = '{1'b1, REG_LOAD, r.ram_rdata, REG_ZERO, 8'h00};
                end
            end
            default:   w = '0;
        endcase
        return w;
    endfunction

    function automatic ram_wr_t ram_store_model(input exec_req_t r);
        ram_wr_t s;
        s = '0;
        if (r.op == OP_MOVEOUT && !r.use_imm) begin
            s = '{1'b1, r.src_ab.word, r.src_ab.bytes.hi};
        end
        return s;
    endfunction

    function automatic word_t pc_model(input exec_req_t r);
        word_t inc;
        word_t seq;
        logic  same;
        inc  = r.pc + 16'd1;
        seq  = r.step_mode ? r.pc : ((r.pc >= ROM_LAST) ? 16'h0000 : inc);
        same = (r.src_ab.bytes.hi == r.src_ab.bytes.lo);
        case (r.op)
            OP_JUMP:   return r.use_imm ? inc : r.src_ab.word;
            OP_EJUMP:  return (!r.use_imm && same) ? r.src_cd.word : inc;
            OP_NEJUMP: return (!r.use_imm && !same) ? r.src_cd.word : inc;
            OP_WAIT:   return (r.wait_ctrl == WAIT_HOLD || r.wait_ctrl == WAIT_HOLD_HIGH) ?
                              r.pc : seq;
            default:   return seq;
        endcase
    endfunction

    // --------------------
    // Drive and check
    // --------------------

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "output mismatch in %s", name);
        end
    endtask

    task automatic check_pending();
        if (pend_valid) begin
            check_value({pend_name, " reg_wr"}, 64'(pend_reg), 64'(reg_wr));
            check_value({pend_name, " ram_wr"}, 64'(pend_ram), 64'(ram_wr));
            check_value({pend_name, " pc"}, 64'(pend_pc), 64'(pc));
        end
    endtask

    // One request per cycle, the previous one checked at the falling edge
    task automatic apply_request(input exec_req_t req, input reg_wr_t exp_reg,
                                 input ram_wr_t exp_ram, input word_t exp_pc,
                                 input string name);
        @(posedge clk_i);
        req_i <= req;
        @(negedge clk_i);
        check_pending();
        pend_valid = 1'b1;
        pend_name  = name;
        pend_reg   = exp_reg;
        pend_ram   = exp_ram;
        pend_pc    = exp_pc;
    endtask

    task automatic flush_pending();
        @(posedge clk_i);
        req_i <= '0;
        @(negedge clk_i);
        check_pending();
        pend_valid = 1'b0;
    endtask

    initial begin
        exec_req_t rnd_req;
        rst_i      = 1'b1;
        req_i      = reset_busy_req(1'b0);
        pend_valid = 1'b0;
        lfsr_state = LFSR_SEED;

        // Register writes and stores alternate while reset holds the outputs
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk_i);
            if (i == RESET_CYCLES - 1) begin
                rst_i <= 1'b0;
                req_i <= '0;
            end
            else begin
                req_i <= reset_busy_req(i % 2 == 0);
            end
            @(negedge clk_i);
            check_value($sformatf("reset %0d reg_wr", i), 64'd0, 64'(reg_wr));
            check_value($sformatf("reset %0d ram_wr", i), 64'd0, 64'(ram_wr));
            check_value($sformatf("reset %0d pc", i), 64'd0, 64'(pc));
        end

        for (int i = 0; i < NUM_VECTORS; i++) begin
            apply_request(EXEC_VECTORS[i].req, EXEC_VECTORS[i].reg_wr,
                          EXEC_VECTORS[i].ram_wr, EXEC_VECTORS[i].pc,
                          $sformatf("vector %0d", i));
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            build_random_req(rnd_req);
            apply_request(rnd_req, reg_write_model(rnd_req), ram_store_model(rnd_req),
                          pc_model(rnd_req), $sformatf("random %0d", i));
        end
        flush_pending();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
design/exec_pkg.sv
design/operand_select.sv
design/result_unit.sv
design/pc_unit.sv
design/exec_stage.sv
bench/exec_stage_properties.sv
bench/exec_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_stage_tb \
    -f all.f \
    -o exec_stage_sim

./obj_dir/exec_stage_sim
